// File: verilog/rv_params.svh
/* Width and size macros for the RV32I integer core
   Include wherever a width or register count is needed */

`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data path width, PCs and operands alike
`define RV_XLEN    32

// Integer register file depth, x0 included
`define RV_NREGS   32

// Register index width
`define RV_RSEL_W  5

`endif

// File: verilog/rv_types_pkg.sv
/* Shared types for the RV32I integer core
   Instruction word views plus opcode and ALU select encodings */

`include "rv_params.svh"

package rv_types_pkg;

    typedef logic [`RV_XLEN-1:0]   rv_word_t;   // Data word, PC, operand
    typedef logic [`RV_RSEL_W-1:0] rv_rsel_t;   // Register index

    // Major opcode, instruction bits [6:2]
    typedef enum logic [4:0] {
        OP_LUI   = 5'b01101,
        OP_AUIPC = 5'b00101,
        OP_OPIMM = 5'b00100,
        OP_OP    = 5'b01100
    } rv_opcode_e;

    // ALU result select
    typedef enum logic [2:0] {
        ALU_ADDER = 3'd0,    // Add or subtract
        ALU_COMP  = 3'd1,    // Set-less-than
        ALU_XOR   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_AND   = 3'd4,
        ALU_SHIFT = 3'd5     // Left or right, logical or arithmetic
    } rv_alu_sel_e;

    // One instruction word seen through three formats
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            rv_rsel_t   rs2;
            rv_rsel_t   rs1;
            logic [2:0] funct3;
            rv_rsel_t   rd;
            logic [6:0] opcode;
        } r;                     // Register fields
        struct packed {
            logic [11:0] imm12;
            rv_rsel_t    rs1;
            logic [2:0]  funct3;
            rv_rsel_t    rd;
            logic [6:0]  opcode;
        } i;                     // 12-bit immediate
        struct packed {
            logic [19:0] imm20;
            rv_rsel_t    rd;
            logic [6:0]  opcode;
        } u;                     // Upper 20-bit immediate
    } rv_instr_u;

endpackage

// File: verilog/rv_alu.sv
/* Combinational ALU of the execute stage
   Shared adder for add, sub and compare, one right shifter for all shifts */

`timescale 1ns/100ps
`include "rv_params.svh"

module rv_alu
    import rv_types_pkg::*;
(
    input  rv_word_t    op1,
    input  rv_word_t    op2,
    input  logic        cin,      // Subtract, op2 inverted plus one
    input  logic        rev,      // Left shift through bit reversal
    input  logic        uns,      // Unsigned compare, logical shift
    input  rv_alu_sel_e sel,
    output rv_word_t    result
);

    rv_word_t          op2_eff;
    logic [`RV_XLEN:0] sum;       // Carry out on top
    logic              lt;
    logic [4:0]        shamt;
    logic              fill;
    rv_word_t          sh_in, sh_out;
    logic [`RV_XLEN:0] sh_ext;

    function automatic rv_word_t bit_rev(input rv_word_t val);
        rv_word_t rv;
        for (int b = 0; b < `RV_XLEN; b++) begin
            rv[b] = val[`RV_XLEN-1-b];
        end
        return rv;
    endfunction

    // ======================================================================
    // Adder and compare

    assign op2_eff = cin ? ~op2 : op2;
    assign sum     = {1'b0, op1} + {1'b0, op2_eff} + {{`RV_XLEN{1'b0}}, cin};

    always_comb begin
        if (uns) lt = ~sum[`RV_XLEN];                                // No carry means borrow
        else if (op1[`RV_XLEN-1] != op2[`RV_XLEN-1]) lt = op1[`RV_XLEN-1];  // Signs differ
        else lt = sum[`RV_XLEN-1];
    end

    // ======================================================================
    // Shifter

    assign shamt  = op2[4:0];
    assign sh_in  = rev ? bit_rev(op1) : op1;
    assign fill   = ~uns & sh_in[`RV_XLEN-1];     // Sign fill for SRA only
    assign sh_ext = $signed({fill, sh_in}) >>> shamt;
    assign sh_out = rev ? bit_rev(sh_ext[`RV_XLEN-1:0]) : sh_ext[`RV_XLEN-1:0];

    // Result select
    always_comb begin
        case (sel)
            ALU_COMP:  result = {{(`RV_XLEN-1){1'b0}}, lt};
            ALU_XOR:   result = op1 ^ op2;
            ALU_OR:    result = op1 | op2;
            ALU_AND:   result = op1 & op2;
            ALU_SHIFT: result = sh_out;
            default:   result = sum[`RV_XLEN-1:0];      // ALU_ADDER
        endcase
    end

endmodule

// File: verilog/rv_decode.sv
/* Decode stage with register file, immediate builder and control decode
   Takes instruction words by valid/ready and hands operands to execute */

`timescale 1ns/100ps
`include "rv_params.svh"

module rv_decode
    import rv_types_pkg::*;
(
    input  logic        clk,
    input  logic        rstz,
    // Instruction in
    input  rv_instr_u   instr_ir,
    input  rv_word_t    instr_pc,
    input  logic        instr_vld,
    output logic        instr_rdy,
    // Decoded instruction out
    output rv_word_t    dec_op1,
    output rv_word_t    dec_op2,
    output logic        dec_cin,
    output logic        dec_rev,
    output logic        dec_uns,
    output rv_alu_sel_e dec_sel,
    output rv_rsel_t    dec_rd,
    output logic        dec_rd_write,
    output logic        dec_illegal,
    output logic        dec_vld,
    input  logic        dec_rdy,
    // Write-back from execute
    input  logic        regwr_en,
    input  rv_rsel_t    regwr_sel,
    input  rv_word_t    regwr_data
);

    logic [4:0]  opc;                   // Opcode bits [6:2]
    logic        illegal_opcode;
    logic        instr_valid;
    logic        xfer_in;
    logic        f7_zero, f7_alt, is_op;
    rv_word_t    reg1 [`RV_NREGS];      // Copy for rs1 port
    rv_word_t    reg2 [`RV_NREGS];      // Copy for rs2 port
    rv_word_t    rs1_data, rs2_data;    // Falling edge read
    rv_word_t    rs1_val, rs2_val;      // After forwarding
    logic        sign, format_i, format_u;
    logic        imm_a;
    logic [3:0]  imm_b;
    logic [5:0]  imm_c;
    logic        imm_d;
    logic [7:0]  imm_e;
    logic [11:0] imm_f;
    rv_word_t    immediate;
    rv_word_t    op1_nxt, op2_nxt;
    logic        cin, rev, uns;
    rv_alu_sel_e sel;

    assign opc            = instr_ir.r.opcode[6:2];
    assign illegal_opcode = instr_ir.r.opcode[1:0] != 2'b11;
    assign f7_zero        = instr_ir.r.funct7 == 7'h00;
    assign f7_alt         = instr_ir.r.funct7 == 7'h20;  // SUB and SRA
    assign is_op          = opc == OP_OP;

    // ======================================================================
    // Integer registers

    // Write on the rising edge, both copies together
    always_ff @(posedge clk) begin
        if (regwr_en) begin
            reg1[regwr_sel] <= regwr_data;
            reg2[regwr_sel] <= regwr_data;
        end
    end

    // Read half a cycle early, so rs fields must settle before the falling edge
    always_ff @(negedge clk) begin
        rs1_data <= reg1[instr_ir.r.rs1];
        rs2_data <= reg2[instr_ir.r.rs2];
    end

    // x0 reads zero, a write landing this edge is forwarded
    always_comb begin
        if (instr_ir.r.rs1 == '0) rs1_val = '0;
        else if (regwr_en && regwr_sel == instr_ir.r.rs1) rs1_val = regwr_data;
        else rs1_val = rs1_data;

        if (instr_ir.r.rs2 == '0) rs2_val = '0;
        else if (regwr_en && regwr_sel == instr_ir.r.rs2) rs2_val = regwr_data;
        else rs2_val = rs2_data;
    end

    // ======================================================================
    // Immediate builder

    assign sign     = instr_ir.i.imm12[11];
    assign format_i = opc == OP_OPIMM;
    assign format_u = opc == OP_LUI || opc == OP_AUIPC;

    always_comb begin
        imm_a = format_i ? instr_ir.i.imm12[0] : 1'b0;            // Bit 0
        imm_b = format_u ? 4'b0 : instr_ir.i.imm12[4:1];          // Bits 4:1
        imm_c = format_u ? 6'b0 : instr_ir.i.imm12[10:5];         // Bits 10:5
        imm_d = format_u ? 1'b0 : sign;                           // Bit 11
        imm_e = format_u ? instr_ir.u.imm20[7:0] : {8{sign}};     // Bits 19:12
        imm_f = format_u ? instr_ir.u.imm20[19:8] : {12{sign}};   // Bits 31:20
    end

    assign immediate = {imm_f, imm_e, imm_d, imm_c, imm_b, imm_a};

    // ======================================================================
    // Control decode

    always_comb begin
        cin         = 1'b0;       // Default is a plain add
        rev         = 1'b0;
        uns         = 1'b0;
        sel         = ALU_ADDER;
        instr_valid = 1'b0;

        case (opc)
            OP_LUI, OP_AUIPC: instr_valid = 1'b1;
            OP_OPIMM, OP_OP: begin
                // funct7 only matters for register forms and shifts
                case (instr_ir.r.funct3)
                    3'b000: begin                          // ADD, SUB, ADDI
                        cin         = is_op & f7_alt;
                        instr_valid = ~is_op | f7_zero | f7_alt;
                    end
                    3'b001: begin                          // SLL, SLLI
                        rev         = 1'b1;
                        uns         = 1'b1;
                        sel         = ALU_SHIFT;
                        instr_valid = f7_zero;
                    end
                    3'b010: begin                          // SLT, SLTI
                        cin         = 1'b1;
                        sel         = ALU_COMP;
                        instr_valid = ~is_op | f7_zero;
                    end
                    3'b011: begin                          // SLTU, SLTIU
                        cin         = 1'b1;
                        uns         = 1'b1;
                        sel         = ALU_COMP;
                        instr_valid = ~is_op | f7_zero;
                    end
                    3'b100: begin
                        sel         = ALU_XOR;
                        instr_valid = ~is_op | f7_zero;
                    end
                    3'b101: begin                          // SRL and SRA forms
                        uns         = ~f7_alt;
                        sel         = ALU_SHIFT;
                        instr_valid = f7_zero | f7_alt;
                    end
                    3'b110: begin
                        sel         = ALU_OR;
                        instr_valid = ~is_op | f7_zero;
                    end
                    default: begin                         // AND, ANDI
                        sel         = ALU_AND;
                        instr_valid = ~is_op | f7_zero;
                    end
                endcase
            end
            default: ;                                     // Unsupported opcode
        endcase
    end

    // Operand select per opcode
    always_comb begin
        op1_nxt = rs1_val;
        op2_nxt = immediate;
        case (opc)
            OP_LUI:   op1_nxt = '0;
            OP_AUIPC: op1_nxt = instr_pc;
            OP_OP:    op2_nxt = rs2_val;
            default: ;                                     // OP-IMM and illegal
        endcase
    end

    // ======================================================================
    // Output register

    assign xfer_in   = instr_vld && instr_rdy;
    assign instr_rdy = ~dec_vld | dec_rdy;     // Empty or draining

    always_ff @(posedge clk or negedge rstz) begin
        if (~rstz) begin
            dec_vld <= 1'b0;
        end else if (xfer_in) begin
            dec_vld <= 1'b1;
        end else if (dec_rdy) begin
            dec_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_in) begin
            dec_op1      <= op1_nxt;
            dec_op2      <= op2_nxt;
            dec_cin      <= cin;
            dec_rev      <= rev;
            dec_uns      <= uns;
            dec_sel      <= sel;
            dec_rd       <= instr_ir.r.rd;
            dec_rd_write <= instr_ir.r.rd != '0;
            dec_illegal  <= ~instr_valid | illegal_opcode;
        end
    end

    // Stalled decode output holds until execute takes it
    a_dec_hold: assert property (@(posedge clk) disable iff (!rstz)
        dec_vld && !dec_rdy |=> dec_vld && $stable({dec_op1, dec_op2, dec_cin, dec_rev,
            dec_uns, dec_sel, dec_rd, dec_rd_write, dec_illegal}));

endmodule

// File: verilog/rv_execute.sv
/* Execute stage, runs the ALU on the offered instruction
   Writes back on accept and registers the result port */

`timescale 1ns/100ps

module rv_execute
    import rv_types_pkg::*;
(
    input  logic        clk,
    input  logic        rstz,
    // Decoded instruction in
    input  rv_word_t    dec_op1,
    input  rv_word_t    dec_op2,
    input  logic        dec_cin,
    input  logic        dec_rev,
    input  logic        dec_uns,
    input  rv_alu_sel_e dec_sel,
    input  rv_rsel_t    dec_rd,
    input  logic        dec_rd_write,
    input  logic        dec_illegal,
    input  logic        dec_vld,
    output logic        dec_rdy,
    // Write-back to decode
    output logic        regwr_en,
    output rv_rsel_t    regwr_sel,
    output rv_word_t    regwr_data,
    // Result out
    output rv_word_t    result_data,
    output rv_rsel_t    result_rd,
    output logic        result_write,
    output logic        result_illegal,
    output logic        result_vld,
    input  logic        result_rdy
);

    rv_word_t alu_result;
    logic     xfer_in;

    rv_alu u_alu (
        .op1    (dec_op1),
        .op2    (dec_op2),
        .cin    (dec_cin),
        .rev    (dec_rev),
        .uns    (dec_uns),
        .sel    (dec_sel),
        .result (alu_result)
    );

    assign dec_rdy = ~result_vld | result_rdy;
    assign xfer_in = dec_vld && dec_rdy;

    // Register file write on the accepting edge
    assign regwr_en   = xfer_in && dec_rd_write && ~dec_illegal;
    assign regwr_sel  = dec_rd;
    assign regwr_data = alu_result;

    // ======================================================================
    // Result register

    always_ff @(posedge clk or negedge rstz) begin
        if (~rstz) begin
            result_vld <= 1'b0;
        end else if (xfer_in) begin
            result_vld <= 1'b1;
        end else if (result_rdy) begin
            result_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_in) begin
            result_data    <= alu_result;
            result_rd      <= dec_rd;
            result_write   <= dec_rd_write;
            result_illegal <= dec_illegal;
        end
    end

    // Write-back never targets x0
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rstz)
        regwr_en |-> regwr_sel != '0);

    // Result holds under back-pressure
    a_result_hold: assert property (@(posedge clk) disable iff (!rstz)
        result_vld && !result_rdy |=> result_vld &&
            $stable({result_data, result_rd, result_write, result_illegal}));

endmodule

// File: verilog/rv_int_core.sv
/* Top of the RV32I integer core, decode followed by execute */

`timescale 1ns/100ps

module rv_int_core
    import rv_types_pkg::*;
(
    input  logic      clk,
    input  logic      rstz,
    // Instruction in
    input  rv_instr_u instr_ir,
    input  rv_word_t  instr_pc,
    input  logic      instr_vld,
    output logic      instr_rdy,
    // Result out
    output rv_word_t  result_data,
    output rv_rsel_t  result_rd,
    output logic      result_write,
    output logic      result_illegal,
    output logic      result_vld,
    input  logic      result_rdy
);

    // Decode to execute
    rv_word_t    dec_op1, dec_op2;
    logic        dec_cin, dec_rev, dec_uns;
    rv_alu_sel_e dec_sel;
    rv_rsel_t    dec_rd;
    logic        dec_rd_write, dec_illegal;
    logic        dec_vld, dec_rdy;

    // Write-back path
    logic        regwr_en;
    rv_rsel_t    regwr_sel;
    rv_word_t    regwr_data;

    rv_decode u_rv_decode (
        .clk, .rstz,
        .instr_ir, .instr_pc, .instr_vld, .instr_rdy,
        .dec_op1, .dec_op2, .dec_cin, .dec_rev, .dec_uns, .dec_sel,
        .dec_rd, .dec_rd_write, .dec_illegal, .dec_vld, .dec_rdy,
        .regwr_en, .regwr_sel, .regwr_data
    );

    rv_execute u_rv_execute (
        .clk, .rstz,
        .dec_op1, .dec_op2, .dec_cin, .dec_rev, .dec_uns, .dec_sel,
        .dec_rd, .dec_rd_write, .dec_illegal, .dec_vld, .dec_rdy,
        .regwr_en, .regwr_sel, .regwr_data,
        .result_data, .result_rd, .result_write, .result_illegal,
        .result_vld, .result_rdy
    );

endmodule

// File: testbench/tb_rv_int_core.sv
/* Random instruction stream testbench for the RV32I integer core
   Checks every result against a register-file model with back-pressure applied */

`timescale 1ns/100ps
`include "rv_params.svh"

module tb_rv_int_core;
    import rv_types_pkg::*;

    localparam int NUM_RAND    = 340;                          // Random part of the stream
    localparam int NUM_INSTR   = NUM_RAND + 2*(`RV_NREGS-1);   // Plus register preload
    localparam int TIMEOUT_CYC = NUM_INSTR*20 + 200;

    // Expected result, pushed in program order
    typedef struct packed {
        rv_word_t data;
        rv_rsel_t rd;
        logic     write;
        logic     illegal;
    } exp_t;

    logic      clk;
    logic      rstz;
    rv_instr_u instr_ir;
    rv_word_t  instr_pc;
    logic      instr_vld;
    logic      instr_rdy;
    rv_word_t  result_data;
    rv_rsel_t  result_rd;
    logic      result_write;
    logic      result_illegal;
    logic      result_vld;
    logic      result_rdy;

    integer    seed = 92064;
    int        errors = 0;
    int        n_acc = 0;                  // Instructions accepted by the core
    int        n_recv = 0;                 // Results taken from the core
    rv_word_t  model_regs [`RV_NREGS];
    exp_t      exp_q [$];

    rv_int_core u_rv_int_core (
        .clk, .rstz,
        .instr_ir, .instr_pc, .instr_vld, .instr_rdy,
        .result_data, .result_rd, .result_write, .result_illegal,
        .result_vld, .result_rdy
    );

    always #5 clk = ~clk;

    // ======================================================================
    // Compare tasks

    task automatic check_word(input string name, input rv_word_t got, input rv_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rsel(input string name, input rv_rsel_t got, input rv_rsel_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // ======================================================================
    // Reference model

    // RISC-V integer op semantics for OP and OP-IMM
    function automatic rv_word_t alu_model(input logic [2:0] f3, input logic alt,
                                           input rv_word_t a, input rv_word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];      // Sign fill
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_step(input rv_instr_u w, input rv_word_t pc);
        exp_t     e;
        rv_word_t imm_i;
        rv_word_t imm_u;
        rv_word_t res;
        logic     legal;
        logic     f7_alt;
        imm_i  = {{20{w.i.imm12[11]}}, w.i.imm12};
        imm_u  = {w.u.imm20, 12'h000};
        f7_alt = w.r.funct7 == 7'h20;
        legal  = 1'b1;
        res    = '0;
        if (w.r.opcode[1:0] != 2'b11) begin
            legal = 1'b0;                                   // Compressed space
        end else begin
            case (w.r.opcode[6:2])
                OP_LUI:   res = imm_u;
                OP_AUIPC: res = pc + imm_u;
                OP_OPIMM: begin
                    if (w.r.funct3 == 3'b001 && w.r.funct7 != 7'h00) legal = 1'b0;
                    if (w.r.funct3 == 3'b101 && w.r.funct7 != 7'h00 && !f7_alt) legal = 1'b0;
                    res = alu_model(w.r.funct3, f7_alt && w.r.funct3 == 3'b101,
                                    model_regs[w.r.rs1], imm_i);
                end
                OP_OP: begin
                    if (w.r.funct7 != 7'h00 &&
                        !(f7_alt && (w.r.funct3 == 3'b000 || w.r.funct3 == 3'b101)))
                        legal = 1'b0;
                    res = alu_model(w.r.funct3, f7_alt, model_regs[w.r.rs1],
                                    model_regs[w.r.rs2]);
                end
                default: legal = 1'b0;
            endcase
        end
        e.data    = res;
        e.rd      = w.r.rd;
        e.write   = w.r.rd != '0;
        e.illegal = ~legal;
        if (legal && w.r.rd != '0) model_regs[w.r.rd] = res;   // x0 stays zero
        exp_q.push_back(e);
    endtask

    // ======================================================================
    // Stimulus generation

    // Favors x0..x3 so dependencies come often
    function automatic rv_rsel_t pick_reg();
        logic [31:0] r;
        r = $random(seed);
        if (r[3:0] < 4'd10) return {3'b000, r[9:8]};
        return r[14:10];
    endfunction

    function automatic rv_instr_u next_instr(input int idx);
        rv_instr_u   w;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [6:0]  kind;
        r0   = $random(seed);
        r1   = $random(seed);
        kind = r0[6:0];
        w    = '0;
        if (idx < `RV_NREGS-1) begin                        // Preload with LUI
            w.u.opcode = {OP_LUI, 2'b11};
            w.u.rd     = rv_rsel_t'(idx + 1);
            w.u.imm20  = r1[19:0];
        end else if (idx < 2*(`RV_NREGS-1)) begin           // Then ADDI onto itself
            w.i.opcode = {OP_OPIMM, 2'b11};
            w.i.rd     = rv_rsel_t'(idx - 30);
            w.i.rs1    = rv_rsel_t'(idx - 30);
            w.i.imm12  = r1[11:0];
        end else if (kind < 7'd16) begin                    // LUI or AUIPC
            w.u.opcode = kind < 7'd8 ? {OP_LUI, 2'b11} : {OP_AUIPC, 2'b11};
            w.u.rd     = pick_reg();
            w.u.imm20  = r1[19:0];
        end else if (kind < 7'd56) begin                    // OP-IMM
            w.i.opcode = {OP_OPIMM, 2'b11};
            w.i.funct3 = r0[9:7];
            w.i.rd     = pick_reg();
            w.i.rs1    = pick_reg();
            w.i.imm12  = r1[11:0];
            if (r0[9:7] == 3'b001) w.r.funct7 = 7'h00;
            if (r0[9:7] == 3'b101) w.r.funct7 = r0[10] ? 7'h20 : 7'h00;
        end else if (kind < 7'd116) begin                   // OP
            w.r.opcode = {OP_OP, 2'b11};
            w.r.funct3 = r0[9:7];
            w.r.rd     = pick_reg();
            w.r.rs1    = pick_reg();
            w.r.rs2    = pick_reg();
            if (r0[10] && (r0[9:7] == 3'b000 || r0[9:7] == 3'b101)) w.r.funct7 = 7'h20;
        end else begin                                      // Illegal words
            w = r1;
            case (r0[12:11])
                2'b00:   w.r.opcode[1:0] = {1'b0, r0[13]};
                2'b01:   w.r.opcode = 7'b1100011;           // Branch is unsupported here
                2'b10: begin
                    w.r.opcode = {OP_OP, 2'b11};
                    w.r.funct7 = r0[15] ? 7'h01 : 7'h40;
                end
                default: begin                              // SLLI with funct7 set
                    w.r.opcode = {OP_OPIMM, 2'b11};
                    w.r.funct3 = 3'b001;
                    w.r.funct7 = 7'h20;
                end
            endcase
        end
        return w;
    endfunction

    // ======================================================================
    // Monitor sampled on the rising edge

    always @(posedge clk) begin
        exp_t e;
        if (rstz) begin
            if (result_vld && result_rdy) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Result at %0t arrived with no instruction outstanding", $time);
                end else begin
                    e = exp_q.pop_front();
                    check_flag("result_illegal", result_illegal, e.illegal);
                    check_rsel("result_rd", result_rd, e.rd);
                    check_flag("result_write", result_write, e.write);
                    if (!e.illegal) check_word("result_data", result_data, e.data);
                end
                n_recv++;
            end
            if (instr_vld && instr_rdy) begin
                model_step(instr_ir, instr_pc);
                n_acc++;
            end
        end
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Timeout after %0d cycles with %0d of %0d results received",
                 TIMEOUT_CYC, n_recv, NUM_INSTR);
        $display("=== FAIL ===");
        $finish;
    end

    // ======================================================================
    // Driver with all inputs changed on the falling edge

    initial begin
        logic [31:0] rnd;
        rv_word_t    pc;
        int          issued;
        bit          staged;                   // Word loaded with vld held low one cycle
        bit          offered;                  // vld high, waiting for accept
        clk        = 1'b0;
        rstz       = 1'b0;
        instr_ir   = '0;
        instr_pc   = '0;
        instr_vld  = 1'b0;
        result_rdy = 1'b0;
        pc         = 32'h0000_1000;
        issued     = 0;
        staged     = 1'b0;
        offered    = 1'b0;
        foreach (model_regs[i]) model_regs[i] = '0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rstz <= 1'b1;

        // New word goes out with vld low so the falling edge read sees its rs fields
        while (n_acc < NUM_INSTR) begin
            @(negedge clk);
            rnd = $random(seed);
            result_rdy <= rnd[1:0] != 2'b00;
            if (offered && n_acc == issued) begin      // Taken at last rising edge
                offered = 1'b0;
                instr_vld <= 1'b0;
            end
            if (!offered) begin
                if (staged) begin
                    if (rnd[4:2] != 3'b000) begin      // Occasional extra gap
                        instr_vld <= 1'b1;
                        offered = 1'b1;
                        staged  = 1'b0;
                        issued++;
                    end
                end else if (issued < NUM_INSTR) begin
                    instr_ir <= next_instr(issued);
                    instr_pc <= pc;
                    pc       = pc + 4;
                    staged   = 1'b1;
                end
            end
        end

        // Drain the pipe with ready held high
        @(negedge clk);
        result_rdy <= 1'b1;
        while (n_recv < NUM_INSTR) @(negedge clk);
        repeat (4) @(negedge clk);                     // Catch duplicates

        if (n_recv != n_acc || exp_q.size() != 0) begin
            errors++;
            $display("Result count %0d does not match %0d accepted instructions", n_recv, n_acc);
        end
        $display("Accepted %0d, received %0d, errors %0d", n_acc, n_recv, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+verilog
verilog/rv_types_pkg.sv
verilog/rv_alu.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_int_core.sv
testbench/tb_rv_int_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the integer core testbench with Verilator and run it
# Exit status is nonzero unless the log holds the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_rv_int_core \
    -Mdir obj_dir -o sim > build.log 2>&1 \
    && ./obj_dir/sim > sim.log 2>&1 \
    && grep -q "^=== PASS ===$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
